//--- tb.f
verilog/ntps_pkg.sv
verilog/reg_bus_if.sv
verilog/axi_slot_decoder.sv
verilog/network_path_regs.sv
verilog/ntp_clock_select.sv
verilog/ntps_interfaces.sv
bench/tb_clock.sv
bench/tb_ntps_interfaces.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register top level testbench with Verilator.
# The exit status is the simulation result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_ntps_interfaces \
  -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim \
  || { echo "Simulation build or run failed"; exit 1; }

//--- bench/tb_ntps_interfaces.sv
/*
 * Testbench for the NTP server interface register top level.
 * Random AXI-lite traffic against a register model, status readback,
 * API command pulses, unmapped slots, and a cycle model of the
 * NTP source selector.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ntps_interfaces;

  localparam int NUM_PORTS = 4;
  localparam int AW        = ntps_pkg::AXI_ADDR_W;
  localparam int DW        = ntps_pkg::AXI_DATA_W;
  localparam int SW        = ntps_pkg::AXI_STRB_W;
  localparam int XW        = ntps_pkg::XPHY_STATUS_W;
  localparam int CW        = ntps_pkg::API_CMD_W;
  localparam int TW        = ntps_pkg::API_STATUS_W;
  localparam int TIMEOUT   = 64;
  localparam int R_CFG     = int'(ntps_pkg::REG_GEN_CONFIG);
  localparam int R_XPHY    = int'(ntps_pkg::REG_XPHY_STATUS);
  localparam int R_SYNC    = int'(ntps_pkg::REG_NTP_SYNC);
  localparam int R_ADDR    = int'(ntps_pkg::REG_EXT_ADDRESS);
  localparam int R_WDATA   = int'(ntps_pkg::REG_EXT_WDATA);
  localparam int R_CMD     = int'(ntps_pkg::REG_EXT_COMMAND);
  localparam int R_STAT    = int'(ntps_pkg::REG_EXT_STATUS);
  localparam int R_RDATA   = int'(ntps_pkg::REG_EXT_RDATA);

  logic                      axi_aclk;
  logic                      reset;
  logic [AW-1:0]             s_axi_awaddr;
  logic                      s_axi_awvalid;
  logic                      s_axi_awready;
  logic [DW-1:0]             s_axi_wdata;
  logic [SW-1:0]             s_axi_wstrb;
  logic                      s_axi_wvalid;
  logic                      s_axi_wready;
  logic [1:0]                s_axi_bresp;
  logic                      s_axi_bvalid;
  logic                      s_axi_bready;
  logic [AW-1:0]             s_axi_araddr;
  logic                      s_axi_arvalid;
  logic                      s_axi_arready;
  logic [DW-1:0]             s_axi_rdata;
  logic [1:0]                s_axi_rresp;
  logic                      s_axi_rvalid;
  logic                      s_axi_rready;
  logic [NUM_PORTS*XW-1:0]   xphy_status;
  logic [NUM_PORTS*CW-1:0]   api_ext_command;
  logic [NUM_PORTS*DW-1:0]   api_ext_address;
  logic [NUM_PORTS*DW-1:0]   api_ext_write_data;
  logic [NUM_PORTS*TW-1:0]   api_ext_status;
  logic [NUM_PORTS*DW-1:0]   api_ext_read_data;
  logic [63:0]               ntp_time_a;
  logic                      ntp_time_upd_a;
  logic                      ntp_sync_ok_a;
  logic [63:0]               ntp_time_b;
  logic                      ntp_time_upd_b;
  logic                      ntp_sync_ok_b;
  logic [63:0]               ntp_time;
  logic                      ntp_sync_ok;

  // Register model and expected selector state
  logic [DW-1:0]             model_cfg [NUM_PORTS];
  logic [DW-1:0]             model_addr [NUM_PORTS];
  logic [DW-1:0]             model_wdata [NUM_PORTS];
  logic [63:0]               exp_time;
  logic                      exp_sync;
  logic                      sync_at_accept;
  logic                      ntp_drive_en;
  logic [NUM_PORTS*CW-1:0]   cmd_first;
  logic [NUM_PORTS*CW-1:0]   cmd_second;
  integer                    seed;

  tb_clock clock_i (
    .axi_aclk (axi_aclk),
    .reset    (reset)
  );

  ntps_interfaces #(.NUM_PORTS(NUM_PORTS)) dut_i (.*);

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  function automatic logic [AW-1:0] reg_addr(input int slot, input int reg_idx);
    return AW'((slot << ntps_pkg::SLOT_LSB) | (reg_idx << 2));
  endfunction

  function automatic int rw_reg(input int k);
    if (k == 0) return R_CFG;
    if (k == 1) return R_ADDR;
    return R_WDATA;
  endfunction

  function automatic logic [DW-1:0] apply_strobes(input logic [DW-1:0] old_word,
                                                  input logic [DW-1:0] new_word,
                                                  input logic [SW-1:0] strb);
    logic [DW-1:0] result;
    result = old_word;
    for (int b = 0; b < SW; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic logic [DW-1:0] model_value(input int port, input int reg_idx);
    if (reg_idx == R_CFG) return model_cfg[port];
    if (reg_idx == R_ADDR) return model_addr[port];
    return model_wdata[port];
  endfunction

  task automatic update_model(input int port, input int reg_idx,
                              input logic [DW-1:0] data, input logic [SW-1:0] strb);
    if (reg_idx == R_CFG) model_cfg[port] = apply_strobes(model_cfg[port], data, strb);
    if (reg_idx == R_ADDR) model_addr[port] = apply_strobes(model_addr[port], data, strb);
    if (reg_idx == R_WDATA) model_wdata[port] = apply_strobes(model_wdata[port], data, strb);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_timeout(input int cnt, input string what);
    if (cnt > TIMEOUT) begin
      $display("Timed out at %0t ns waiting for %s", $time, what);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  // --------------------
  // AXI-lite tasks
  // --------------------
  // All start and end 2 ns after a rising edge
  task automatic axi_write(input int slot, input int reg_idx, input logic [DW-1:0] data,
                           input logic [SW-1:0] strb, input logic [1:0] exp_resp);
    int          wait_cnt;
    logic [31:0] delay_bits;
    s_axi_awaddr  = reg_addr(slot, reg_idx);
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    wait_cnt = 0;
    @(negedge axi_aclk);
    while (!(s_axi_awready && s_axi_wready)) begin
      wait_cnt++;
      check_timeout(wait_cnt, "awready and wready");
      @(negedge axi_aclk);
    end
    @(posedge axi_aclk);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    if (slot < NUM_PORTS) update_model(slot, reg_idx, data, strb);
    fork
      begin
        // Command outputs in the two cycles after acceptance
        @(negedge axi_aclk);
        cmd_first = api_ext_command;
        @(negedge axi_aclk);
        cmd_second = api_ext_command;
        @(posedge axi_aclk);
        #2;
      end
      begin
        delay_bits = random_word();
        repeat (int'(delay_bits[1:0])) begin
          @(posedge axi_aclk);
          #2;
        end
        s_axi_bready = 1'b1;
        wait_cnt = 0;
        @(negedge axi_aclk);
        while (!s_axi_bvalid) begin
          wait_cnt++;
          check_timeout(wait_cnt, "bvalid");
          @(negedge axi_aclk);
        end
        check_value("s_axi_bresp", 64'(s_axi_bresp), 64'(exp_resp));
        @(posedge axi_aclk);
        #2;
        s_axi_bready = 1'b0;
      end
    join
  endtask

  task automatic axi_read(input int slot, input int reg_idx, input logic [1:0] exp_resp,
                          output logic [DW-1:0] data);
    int          wait_cnt;
    logic [31:0] delay_bits;
    s_axi_araddr  = reg_addr(slot, reg_idx);
    s_axi_arvalid = 1'b1;
    wait_cnt = 0;
    @(negedge axi_aclk);
    while (!s_axi_arready) begin
      wait_cnt++;
      check_timeout(wait_cnt, "arready");
      @(negedge axi_aclk);
    end
    // Sync flag as the port captures it at the accepting edge
    sync_at_accept = exp_sync;
    @(posedge axi_aclk);
    #2;
    s_axi_arvalid = 1'b0;
    delay_bits = random_word();
    repeat (int'(delay_bits[1:0])) begin
      @(posedge axi_aclk);
      #2;
    end
    s_axi_rready = 1'b1;
    wait_cnt = 0;
    @(negedge axi_aclk);
    while (!s_axi_rvalid) begin
      wait_cnt++;
      check_timeout(wait_cnt, "rvalid");
      @(negedge axi_aclk);
    end
    check_value("s_axi_rresp", 64'(s_axi_rresp), 64'(exp_resp));
    data = s_axi_rdata;
    @(posedge axi_aclk);
    #2;
    s_axi_rready = 1'b0;
  endtask

  task automatic read_check(input int slot, input int reg_idx, input logic [DW-1:0] expected);
    logic [DW-1:0] data;
    axi_read(slot, reg_idx, ntps_pkg::RESP_OKAY, data);
    check_value("s_axi_rdata", 64'(data), 64'(expected));
  endtask

  task automatic check_rw_regs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < 3; k++) begin
        read_check(p, rw_reg(k), model_value(p, rw_reg(k)));
      end
      check_value("api_ext_address", 64'(api_ext_address[p*DW +: DW]), 64'(model_addr[p]));
      check_value("api_ext_write_data", 64'(api_ext_write_data[p*DW +: DW]),
                  64'(model_wdata[p]));
    end
  endtask

  // --------------------
  // NTP source model
  // --------------------
  // Edge update, drive 2 ns later, compare at the falling edge
  task automatic run_ntp_model();
    logic [31:0] bits;
    forever begin
      @(posedge axi_aclk);
      if (reset) begin
        exp_time = '0;
        exp_sync = 1'b0;
      end else if (model_cfg[0][24]) begin
        if (ntp_time_upd_b) exp_time = ntp_time_b;
        exp_sync = ntp_sync_ok_b;
      end else begin
        if (ntp_time_upd_a) exp_time = ntp_time_a;
        exp_sync = ntp_sync_ok_a;
      end
      #2;
      if (ntp_drive_en) begin
        bits           = random_word();
        ntp_time_a     = {random_word(), random_word()};
        ntp_time_b     = {random_word(), random_word()};
        ntp_time_upd_a = bits[0] & bits[1];
        ntp_time_upd_b = bits[2] & bits[3];
        ntp_sync_ok_a  = bits[4];
        ntp_sync_ok_b  = bits[5];
      end
      @(negedge axi_aclk);
      if (!reset) begin
        check_value("ntp_time", ntp_time, exp_time);
        check_value("ntp_sync_ok", 64'(ntp_sync_ok), 64'(exp_sync));
      end
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    logic [DW-1:0] data;
    logic [31:0]   rnd;
    int            wait_cnt;
    seed               = 32'h1ba1_d588;
    ntp_drive_en       = 1'b0;
    s_axi_awaddr       = '0;
    s_axi_awvalid      = 1'b0;
    s_axi_wdata        = '0;
    s_axi_wstrb        = '0;
    s_axi_wvalid       = 1'b0;
    s_axi_bready       = 1'b0;
    s_axi_araddr       = '0;
    s_axi_arvalid      = 1'b0;
    s_axi_rready       = 1'b0;
    xphy_status        = '0;
    api_ext_status     = '0;
    api_ext_read_data  = '0;
    ntp_time_a         = '0;
    ntp_time_upd_a     = 1'b0;
    ntp_sync_ok_a      = 1'b0;
    ntp_time_b         = '0;
    ntp_time_upd_b     = 1'b0;
    ntp_sync_ok_b      = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      model_cfg[p]   = '0;
      model_addr[p]  = '0;
      model_wdata[p] = '0;
    end
    fork
      run_ntp_model();
    join_none

    wait_cnt = 0;
    @(negedge axi_aclk);
    while (reset) begin
      wait_cnt++;
      check_timeout(wait_cnt, "reset release");
      @(negedge axi_aclk);
    end
    check_value("s_axi_awready", 64'(s_axi_awready), 64'd0);
    check_value("s_axi_wready", 64'(s_axi_wready), 64'd0);
    check_value("s_axi_arready", 64'(s_axi_arready), 64'd0);
    check_value("s_axi_bvalid", 64'(s_axi_bvalid), 64'd0);
    check_value("s_axi_rvalid", 64'(s_axi_rvalid), 64'd0);
    check_value("api_ext_command", 64'(api_ext_command), 64'd0);
    check_value("ntp_time", ntp_time, 64'd0);
    check_value("ntp_sync_ok", 64'(ntp_sync_ok), 64'd0);
    @(posedge axi_aclk);
    #2;

    // Read-write registers with byte strobes
    for (int n = 0; n < 48; n++) begin
      rnd = random_word();
      axi_write(int'(rnd[2:0]) % NUM_PORTS, rw_reg(int'(rnd[4:3]) % 3), random_word(),
                rnd[8:5], ntps_pkg::RESP_OKAY);
    end
    check_rw_regs();

    // Read-only status, held steady
    for (int p = 0; p < NUM_PORTS; p++) begin
      rnd = random_word();
      xphy_status[p*XW +: XW]       = rnd[XW-1:0];
      api_ext_status[p*TW +: TW]    = rnd[8 +: TW];
      api_ext_read_data[p*DW +: DW] = random_word();
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      read_check(p, R_XPHY, DW'(xphy_status[p*XW +: XW]));
      read_check(p, R_STAT, DW'(api_ext_status[p*TW +: TW]));
      read_check(p, R_RDATA, api_ext_read_data[p*DW +: DW]);
      read_check(p, R_CMD, '0);
    end

    // Command pulse on the written port only
    for (int p = 0; p < NUM_PORTS; p++) begin
      data = random_word();
      axi_write(p, R_CMD, data, 4'hf, ntps_pkg::RESP_OKAY);
      for (int q = 0; q < NUM_PORTS; q++) begin
        check_value("api_ext_command after write", 64'(cmd_first[q*CW +: CW]),
                    (q == p) ? 64'(data[CW-1:0]) : 64'd0);
        check_value("api_ext_command one cycle later", 64'(cmd_second[q*CW +: CW]), 64'd0);
      end
      // Still reads as zero once a command has been written
      read_check(p, R_CMD, '0);
    end

    // Unmapped slots
    for (int s = NUM_PORTS; s < (1 << ntps_pkg::SLOT_W); s++) begin
      rnd = random_word();
      axi_write(s, int'(rnd[2:0]), random_word(), 4'hf, ntps_pkg::RESP_DECERR);
      check_value("api_ext_command after unmapped write", 64'(cmd_first), 64'd0);
      axi_read(s, int'(rnd[5:3]), ntps_pkg::RESP_DECERR, data);
      check_value("s_axi_rdata", 64'(data), 64'd0);
    end
    check_rw_regs();

    // NTP source switching under random clock traffic
    ntp_drive_en = 1'b1;
    for (int n = 0; n < 8; n++) begin
      rnd      = random_word();
      data     = random_word();
      data[24] = ~model_cfg[0][24];
      axi_write(0, R_CFG, data, rnd[3:0] | 4'b1000, ntps_pkg::RESP_OKAY);
      repeat (12) @(posedge axi_aclk);
      #2;
      axi_read(int'(rnd[6:4]) % NUM_PORTS, R_SYNC, ntps_pkg::RESP_OKAY, data);
      check_value("s_axi_rdata", 64'(data), 64'(sync_at_accept));
    end
    ntp_drive_en = 1'b0;
    repeat (4) @(posedge axi_aclk);

    $display(">>> PASS");
    $finish;
  end

  // Overall limit on simulated time
  initial begin
    #1_000_000;
    $display("Simulation time limit reached before the test sequence finished");
    $display(">>> FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/*
 * Testbench clock and reset.
 * 20 ns clock, reset held high over the first four rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic axi_aclk,
  output logic reset
);

  initial begin
    axi_aclk = 1'b0;
    forever #10 axi_aclk = ~axi_aclk;
  end

  // Released just after an edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge axi_aclk);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog/ntps_interfaces.sv
/*
 * Register side top level of the NTP server interfaces.
 * Host AXI-lite slot decoder, one register block per network
 * path port, and the shared NTP time selector.
 */

`timescale 1ns/1ps
`default_nettype none

module ntps_interfaces #(
  parameter int NUM_PORTS = 4
) (
  input  wire                                             axi_aclk,
  input  wire                                             reset,

  // Host bus
  input  wire [ntps_pkg::AXI_ADDR_W-1:0]                  s_axi_awaddr,
  input  wire                                             s_axi_awvalid,
  output logic                                            s_axi_awready,
  input  wire [ntps_pkg::AXI_DATA_W-1:0]                  s_axi_wdata,
  input  wire [ntps_pkg::AXI_STRB_W-1:0]                  s_axi_wstrb,
  input  wire                                             s_axi_wvalid,
  output logic                                            s_axi_wready,
  output logic [1:0]                                      s_axi_bresp,
  output logic                                            s_axi_bvalid,
  input  wire                                             s_axi_bready,
  input  wire [ntps_pkg::AXI_ADDR_W-1:0]                  s_axi_araddr,
  input  wire                                             s_axi_arvalid,
  output logic                                            s_axi_arready,
  output logic [ntps_pkg::AXI_DATA_W-1:0]                 s_axi_rdata,
  output logic [1:0]                                      s_axi_rresp,
  output logic                                            s_axi_rvalid,
  input  wire                                             s_axi_rready,

  // Per port, port 0 in the low bits
  input  wire [NUM_PORTS*ntps_pkg::XPHY_STATUS_W-1:0]     xphy_status,
  output logic [NUM_PORTS*ntps_pkg::API_CMD_W-1:0]        api_ext_command,
  output logic [NUM_PORTS*ntps_pkg::AXI_DATA_W-1:0]       api_ext_address,
  output logic [NUM_PORTS*ntps_pkg::AXI_DATA_W-1:0]       api_ext_write_data,
  input  wire [NUM_PORTS*ntps_pkg::API_STATUS_W-1:0]      api_ext_status,
  input  wire [NUM_PORTS*ntps_pkg::AXI_DATA_W-1:0]        api_ext_read_data,

  // NTP clocks
  input  wire [ntps_pkg::NTP_TIME_W-1:0]                  ntp_time_a,
  input  wire                                             ntp_time_upd_a,
  input  wire                                             ntp_sync_ok_a,
  input  wire [ntps_pkg::NTP_TIME_W-1:0]                  ntp_time_b,
  input  wire                                             ntp_time_upd_b,
  input  wire                                             ntp_sync_ok_b,
  output logic [ntps_pkg::NTP_TIME_W-1:0]                 ntp_time,
  output logic                                            ntp_sync_ok
);

  localparam int XW = ntps_pkg::XPHY_STATUS_W;
  localparam int CW = ntps_pkg::API_CMD_W;
  localparam int TW = ntps_pkg::API_STATUS_W;
  localparam int DW = ntps_pkg::AXI_DATA_W;

  ntps_pkg::gen_config_t gen_config [NUM_PORTS];

  reg_bus_if #(.NUM_PORTS(NUM_PORTS)) reg_bus ();

  // --------------------
  // Host side
  // --------------------
  axi_slot_decoder #(.NUM_PORTS(NUM_PORTS)) decoder_i (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .awaddr   (s_axi_awaddr),
    .awvalid  (s_axi_awvalid),
    .awready  (s_axi_awready),
    .wdata    (s_axi_wdata),
    .wstrb    (s_axi_wstrb),
    .wvalid   (s_axi_wvalid),
    .wready   (s_axi_wready),
    .bresp    (s_axi_bresp),
    .bvalid   (s_axi_bvalid),
    .bready   (s_axi_bready),
    .araddr   (s_axi_araddr),
    .arvalid  (s_axi_arvalid),
    .arready  (s_axi_arready),
    .rdata    (s_axi_rdata),
    .rresp    (s_axi_rresp),
    .rvalid   (s_axi_rvalid),
    .rready   (s_axi_rready),
    .bus      (reg_bus.decoder)
  );

  // --------------------
  // Network path ports
  // --------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    network_path_regs #(
      .NUM_PORTS  (NUM_PORTS),
      .PORT_INDEX (p)
    ) regs_i (
      .axi_aclk           (axi_aclk),
      .reset              (reset),
      .bus                (reg_bus.port),
      .xphy_status        (xphy_status[p*XW +: XW]),
      .ntp_sync_ok        (ntp_sync_ok),
      .api_ext_command    (api_ext_command[p*CW +: CW]),
      .api_ext_address    (api_ext_address[p*DW +: DW]),
      .api_ext_write_data (api_ext_write_data[p*DW +: DW]),
      .api_ext_status     (api_ext_status[p*TW +: TW]),
      .api_ext_read_data  (api_ext_read_data[p*DW +: DW]),
      .gen_config         (gen_config[p])
    );
  end

  // Source choice belongs to port 0
  ntp_clock_select clock_select_i (
    .axi_aclk       (axi_aclk),
    .reset          (reset),
    .select         (gen_config[0].fields.ntp_select),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok)
  );

endmodule

`default_nettype wire

//--- verilog/ntp_clock_select.sv
/*
 * NTP time source selection between clock A and clock B.
 * Time is taken on the chosen clock's update pulse, the sync
 * flag is registered every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module ntp_clock_select (
  input  wire                                axi_aclk,
  input  wire                                reset,
  input  wire                                select,

  input  wire [ntps_pkg::NTP_TIME_W-1:0]     ntp_time_a,
  input  wire                                ntp_time_upd_a,
  input  wire                                ntp_sync_ok_a,

  input  wire [ntps_pkg::NTP_TIME_W-1:0]     ntp_time_b,
  input  wire                                ntp_time_upd_b,
  input  wire                                ntp_sync_ok_b,

  output logic [ntps_pkg::NTP_TIME_W-1:0]    ntp_time,
  output logic                               ntp_sync_ok
);

  logic sel_upd;

  // select high means clock B
  assign sel_upd = select ? ntp_time_upd_b : ntp_time_upd_a;

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      if (sel_upd) begin
        ntp_time <= select ? ntp_time_b : ntp_time_a;
      end
      ntp_sync_ok <= select ? ntp_sync_ok_b : ntp_sync_ok_a;
    end
  end

endmodule

`default_nettype wire

//--- verilog/network_path_regs.sv
/*
 * Register block of one network path port.
 * General configuration and API extension address and data with
 * byte strobes, one cycle API command pulse, and a registered read
 * mux over configuration, PHY status, sync flag and extension status.
 */

`timescale 1ns/1ps
`default_nettype none

module network_path_regs #(
  parameter int NUM_PORTS  = 4,
  parameter int PORT_INDEX = 0
) (
  input  wire                                  axi_aclk,
  input  wire                                  reset,
  reg_bus_if.port                              bus,

  input  wire [ntps_pkg::XPHY_STATUS_W-1:0]    xphy_status,
  input  wire                                  ntp_sync_ok,

  output logic [ntps_pkg::API_CMD_W-1:0]       api_ext_command,
  output logic [ntps_pkg::AXI_DATA_W-1:0]      api_ext_address,
  output logic [ntps_pkg::AXI_DATA_W-1:0]      api_ext_write_data,
  input  wire [ntps_pkg::API_STATUS_W-1:0]     api_ext_status,
  input  wire [ntps_pkg::AXI_DATA_W-1:0]       api_ext_read_data,

  output ntps_pkg::gen_config_t                gen_config
);

  localparam int DW = ntps_pkg::AXI_DATA_W;
  localparam int SW = ntps_pkg::AXI_STRB_W;

  // This port's bit in the select vectors
  localparam logic [NUM_PORTS-1:0] PORT_BIT = NUM_PORTS'(1) << PORT_INDEX;

  ntps_pkg::gen_config_t                 gen_config_q;
  logic [DW-1:0]                         ext_address_q;
  logic [DW-1:0]                         ext_wdata_q;
  logic [ntps_pkg::API_CMD_W-1:0]        ext_command_q;
  logic [DW-1:0]                         rdata_q;
  logic                                  wr_en;
  logic                                  rd_en;

  // Only bytes with their strobe set change
  function automatic logic [DW-1:0] merge_bytes(
    input logic [DW-1:0] old_word,
    input logic [DW-1:0] new_word,
    input logic [SW-1:0] strb
  );
    logic [DW-1:0] result;
    result = old_word;
    for (int b = 0; b < SW; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign wr_en = |(bus.wr_sel & PORT_BIT);
  assign rd_en = |(bus.rd_sel & PORT_BIT);

  // --------------------
  // Writable registers
  // --------------------
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      gen_config_q.raw <= '0;
      ext_address_q    <= '0;
      ext_wdata_q      <= '0;
    end else if (wr_en) begin
      case (bus.addr)
        ntps_pkg::REG_GEN_CONFIG:
          gen_config_q.raw <= merge_bytes(gen_config_q.raw, bus.wdata, bus.wstrb);
        ntps_pkg::REG_EXT_ADDRESS:
          ext_address_q <= merge_bytes(ext_address_q, bus.wdata, bus.wstrb);
        ntps_pkg::REG_EXT_WDATA:
          ext_wdata_q <= merge_bytes(ext_wdata_q, bus.wdata, bus.wstrb);
        default: ;
      endcase
    end
  end

  // Command lives for one cycle after the write, zero otherwise
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      ext_command_q <= '0;
    end else if (wr_en && (bus.addr == ntps_pkg::REG_EXT_COMMAND)) begin
      ext_command_q <= bus.wdata[ntps_pkg::API_CMD_W-1:0];
    end else begin
      ext_command_q <= '0;
    end
  end

  // --------------------
  // Read mux
  // --------------------
  // Captured on the read strobe and held while the host waits
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      case (bus.addr)
        ntps_pkg::REG_GEN_CONFIG:  rdata_q <= gen_config_q.raw;
        ntps_pkg::REG_XPHY_STATUS: rdata_q <= DW'(xphy_status);
        ntps_pkg::REG_NTP_SYNC:    rdata_q <= DW'(ntp_sync_ok);
        ntps_pkg::REG_EXT_ADDRESS: rdata_q <= ext_address_q;
        ntps_pkg::REG_EXT_WDATA:   rdata_q <= ext_wdata_q;
        ntps_pkg::REG_EXT_STATUS:  rdata_q <= DW'(api_ext_status);
        ntps_pkg::REG_EXT_RDATA:   rdata_q <= api_ext_read_data;
        default:                   rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata[PORT_INDEX] = rdata_q;

  assign api_ext_command    = ext_command_q;
  assign api_ext_address    = ext_address_q;
  assign api_ext_write_data = ext_wdata_q;
  assign gen_config         = gen_config_q;

endmodule

`default_nettype wire

//--- verilog/axi_slot_decoder.sv
/*
 * AXI-lite slave for the register side.
 * Serves one transaction at a time, write before read, splits the
 * address into a port slot and a word offset, and turns each access
 * into a strobe on the reg bus. Unmapped slots answer DECERR.
 */

`timescale 1ns/1ps
`default_nettype none

module axi_slot_decoder #(
  parameter int NUM_PORTS = 4
) (
  input  wire                                axi_aclk,
  input  wire                                reset,

  input  wire [ntps_pkg::AXI_ADDR_W-1:0]     awaddr,
  input  wire                                awvalid,
  output logic                               awready,
  input  wire [ntps_pkg::AXI_DATA_W-1:0]     wdata,
  input  wire [ntps_pkg::AXI_STRB_W-1:0]     wstrb,
  input  wire                                wvalid,
  output logic                               wready,
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  wire                                bready,
  input  wire [ntps_pkg::AXI_ADDR_W-1:0]     araddr,
  input  wire                                arvalid,
  output logic                               arready,
  output logic [ntps_pkg::AXI_DATA_W-1:0]    rdata,
  output logic [1:0]                         rresp,
  output logic                               rvalid,
  input  wire                                rready,

  reg_bus_if.decoder                         bus
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRESP = 2'd1;
  localparam logic [1:0] ST_RRESP = 2'd2;

  // Byte address to word offset
  localparam int WORD_LSB = $clog2(ntps_pkg::AXI_STRB_W);

  logic [1:0]                        state;
  logic [1:0]                        resp;
  logic                              wr_accept;
  logic                              rd_accept;
  logic [ntps_pkg::SLOT_W-1:0]       aw_slot;
  logic [ntps_pkg::SLOT_W-1:0]       ar_slot;
  logic [ntps_pkg::SLOT_W-1:0]       rd_slot;
  logic                              aw_hit;
  logic                              ar_hit;

  // --------------------
  // Accept and decode
  // --------------------
  assign aw_slot = awaddr[ntps_pkg::SLOT_LSB +: ntps_pkg::SLOT_W];
  assign ar_slot = araddr[ntps_pkg::SLOT_LSB +: ntps_pkg::SLOT_W];
  assign aw_hit  = int'(aw_slot) < NUM_PORTS;
  assign ar_hit  = int'(ar_slot) < NUM_PORTS;

  // Write wins when both channels are ready in the same cycle
  assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
  assign rd_accept = (state == ST_IDLE) && arvalid && !wr_accept;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  // One hot strobes, none for an unmapped slot
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      bus.wr_sel[i] = wr_accept && (int'(aw_slot) == i);
      bus.rd_sel[i] = rd_accept && (int'(ar_slot) == i);
    end
  end

  assign bus.addr  = wr_accept ? awaddr[WORD_LSB +: ntps_pkg::REG_ADDR_W]
                               : araddr[WORD_LSB +: ntps_pkg::REG_ADDR_W];
  assign bus.wdata = wdata;
  assign bus.wstrb = wstrb;

  // --------------------
  // Response FSM
  // --------------------
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      state <= ST_IDLE;
      resp  <= ntps_pkg::RESP_OKAY;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wr_accept) begin
            state <= ST_WRESP;
            resp  <= aw_hit ? ntps_pkg::RESP_OKAY : ntps_pkg::RESP_DECERR;
          end else if (rd_accept) begin
            state <= ST_RRESP;
            resp  <= ar_hit ? ntps_pkg::RESP_OKAY : ntps_pkg::RESP_DECERR;
          end
        end
        ST_WRESP: begin
          if (bready) begin
            state <= ST_IDLE;
          end
        end
        ST_RRESP: begin
          if (rready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Slot of the read in flight
  always_ff @(posedge axi_aclk) begin
    if (rd_accept) begin
      rd_slot <= ar_slot;
    end
  end

  assign bvalid = (state == ST_WRESP);
  assign rvalid = (state == ST_RRESP);
  assign bresp  = resp;
  assign rresp  = resp;

  // Unmapped slot matches no port and reads as zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (int'(rd_slot) == i) begin
        rdata = bus.rdata[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/reg_bus_if.sv
/*
 * Register access bus from the slot decoder to the port blocks.
 * One write and one read select bit per port, shared offset,
 * write data and strobes, and one read data word per port.
 */

`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if #(
  parameter int NUM_PORTS = 4
);

  // Single cycle strobes, at most one bit set
  logic [NUM_PORTS-1:0]              wr_sel;
  logic [NUM_PORTS-1:0]              rd_sel;

  logic [ntps_pkg::REG_ADDR_W-1:0]   addr;
  logic [ntps_pkg::AXI_DATA_W-1:0]   wdata;
  logic [ntps_pkg::AXI_STRB_W-1:0]   wstrb;

  // Valid the cycle after rd_sel, held until the next read
  logic [ntps_pkg::AXI_DATA_W-1:0]   rdata [NUM_PORTS];

  modport decoder (
    output wr_sel, rd_sel, addr, wdata, wstrb,
    input  rdata
  );

  modport port (
    input  wr_sel, rd_sel, addr, wdata, wstrb,
    output rdata
  );

endinterface

`default_nettype wire

//--- verilog/ntps_pkg.sv
/*
 * Shared definitions for the NTP server interface registers:
 * host bus widths, slot and register map, AXI response codes,
 * port signal widths and the general configuration word.
 */

`default_nettype none

package ntps_pkg;

  // --------------------
  // Host bus
  // --------------------
  localparam int AXI_ADDR_W = 12;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = 4;

  // 512 byte slot per port, eight words used inside each slot
  localparam int SLOT_LSB   = 9;
  localparam int SLOT_W     = 3;
  localparam int REG_ADDR_W = 3;

  // --------------------
  // Register map
  // --------------------
  localparam logic [REG_ADDR_W-1:0] REG_GEN_CONFIG  = 3'd0;
  localparam logic [REG_ADDR_W-1:0] REG_XPHY_STATUS = 3'd1;
  localparam logic [REG_ADDR_W-1:0] REG_NTP_SYNC    = 3'd2;
  localparam logic [REG_ADDR_W-1:0] REG_EXT_ADDRESS = 3'd3;
  localparam logic [REG_ADDR_W-1:0] REG_EXT_WDATA   = 3'd4;
  // Write only, reads back as zero
  localparam logic [REG_ADDR_W-1:0] REG_EXT_COMMAND = 3'd5;
  localparam logic [REG_ADDR_W-1:0] REG_EXT_STATUS  = 3'd6;
  localparam logic [REG_ADDR_W-1:0] REG_EXT_RDATA   = 3'd7;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // Port side widths
  localparam int XPHY_STATUS_W = 5;
  localparam int API_CMD_W     = 2;
  localparam int API_STATUS_W  = 2;
  localparam int NTP_TIME_W    = 64;

  // --------------------
  // General configuration
  // --------------------
  // Bus side writes the raw word, the clock selector looks at the fields
  typedef union packed {
    logic [AXI_DATA_W-1:0] raw;
    struct packed {
      logic [6:0]  reserved;
      logic        ntp_select;
      logic [23:0] port_config;
    } fields;
  } gen_config_t;

endpackage

`default_nettype wire
